// File: dv/mips_exec_vectors.txt
// K S AA DDDDDDDD EEEEEEEE, no spaces: kind 1 write, 2 read, 3 execute; S status flags
// AA window address; D write data or instruction; E expected read-back
10847fffffff00000000 // r1 = 7fffffff
10880000000100000000 // r2 = 1
108c8000000000000000 // r3 = 80000000
1090f0f0123400000000 // r4 = f0f01234
10b85555555500000000 // r14 = 55555555
10801234567800000000 // r0 write is dropped
20800000000000000000 // r0 reads zero
20b85555555555555555 // r14 read-back
30940022282080000000 // ADD r5,r1,r2 wraps
3098006230237fffffff // SUBU r6,r3,r2
309c0043382280000001 // SUB r7,r2,r3 wraps
30a000214021fffffffe // ADDU r8,r1,r1
30a40081482470f01234 // AND r9,r4,r1
30a800825025f0f01235 // OR r10,r4,r2
30ac008258270f0fedca // NOR r11,r4,r2
30b0008160268f0fedcb // XOR r12,r4,r1
30b40062682a00000001 // SLT r13,r3,r2 signed
30b8284effff00000000 // SLTI r14,r2,-1 sign-extended
30bc204ffffeffffffff // ADDI r15,r2,-2
30c02430000180000000 // ADDIU r16,r1,1
30c43091ff3400001234 // ANDI r17,r4,ff34 zero-extended
30c83472800180008001 // ORI r18,r3,8001 zero-extended
30cc3893fffff0f0edcb // XORI r19,r4,ffff
30d03c14abcdabcd0000 // LUI r20,abcd
30d40082a80bf0f01234 // MOVN r21,r4,r2 moves
32d40020a80bf0f01234 // MOVN r21,r1,r0 blocked
3184102100107fffffff // BEQ r1,r1 taken
30881022001000000001 // BEQ r1,r2 not taken
31881422001000000001 // BNE r1,r2 taken
30881442001000000001 // BNE r2,r2 not taken
3184040100107fffffff // BGEZ r0 taken
3084046100107fffffff // BGEZ r3 not taken
3184042100107fffffff // BGEZ r1 taken
34840042083f7fffffff // Bad funct
3488fc22000000000001 // Bad opcode

// File: compile.f
+incdir+include
hw/mips_isa_pkg.sv
hw/mips_exec_pkg.sv
hw/alu.sv
hw/alu_decoder.sv
hw/reg_file.sv
hw/exec_wb_slave.sv
hw/mips_exec_top.sv
dv/tb_clk_gen.sv
dv/tb_mips_exec.sv

// File: dv/tb_mips_exec.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module tb_mips_exec;
	import mips_exec_pkg::*;

	logic clk;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	logic [`WB_ADDR_W-1:0] adr;
	word_t dat_i;
	logic [3:0] sel;
	word_t dat_o;
	logic ack;

	// kind[79:76] status[75:72] addr[71:64] data[63:32] expected[31:0]
	logic [79:0] vectors [0:63];
	int num_vec;
	int num_xfers; // Wishbone transfers the vectors will take
	int vec_idx = -1; // -1 during the reset sweep
	int cycle_count = 0;
	int timeout_limit = 0;
	logic [31:0] lfsr = 32'h36c3467b;

	tb_clk_gen tb_clk_gen_i (
		.clk(clk),
		.rst(rst)
	);

	mips_exec_top mips_exec_top_i (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_i(dat_i),
		.sel(sel),
		.dat_o(dat_o),
		.ack(ack)
	);

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
	endfunction

	// Idle gap of 0 to 3 cycles from two LFSR bits
	task automatic idle_random();
		logic [1:0] n;
		lfsr = lfsr_next(lfsr);
		n[0] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		n[1] = lfsr[0];
		repeat (n) @(posedge clk);
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("FAILED dat_o (%s) got %08h expected %08h, vector %0d",
				what, got, exp, vec_idx));
		end
	endtask

	task automatic check_status(input exec_status_t got, input exec_status_t exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("FAILED status got %08h expected %08h, vector %0d",
				got, exp, vec_idx));
		end
	endtask

	// One classic bus cycle with ack due on the edge after the request
	task automatic wb_transfer(input logic wr, input logic [`WB_ADDR_W-1:0] a,
		input word_t d, output word_t rdata);
		int wait_cycles;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= wr;
		adr <= a;
		dat_i <= d;
		sel <= 4'hF;
		wait_cycles = 0;
		@(negedge clk);
		while (!ack) begin // Ack due at the second falling edge
			wait_cycles++;
			@(negedge clk);
		end
		rdata = dat_o; // Read data valid while ack is high
		if (wait_cycles != 1) begin
			stop_with_failure($sformatf("ack came %0d cycles after the request instead of 1",
				wait_cycles));
		end
		@(posedge clk);
		cyc <= 1'b0; // Drop in the cycle after ack
		stb <= 1'b0;
		we <= 1'b0;
		@(negedge clk);
		if (ack) begin
			stop_with_failure("ack stayed high for more than one cycle");
		end
		idle_random();
	endtask

	// Every GPR and the status word must be zero out of reset
	task automatic check_reset_state();
		word_t rdata;
		for (int r = 0; r < `MIPS_NREGS; r++) begin
			wb_transfer(1'b0, 8'(`WB_REG_BASE + r * 4), '0, rdata);
			check_word($sformatf("r%0d after reset", r), rdata, '0);
		end
		wb_transfer(1'b0, `WB_ADDR_STATUS, '0, rdata);
		check_status(exec_status_t'(rdata), '0);
	endtask

	task automatic run_vector(input logic [79:0] v);
		logic [3:0] kind;
		exec_status_t exp_status;
		logic [`WB_ADDR_W-1:0] a;
		word_t d;
		word_t exp;
		word_t rdata;
		kind = v[79:76];
		exp_status = exec_status_t'({28'h0, v[75:72]}); // Low flag bits only
		a = v[71:64];
		d = v[63:32];
		exp = v[31:0];
		case (kind)
			4'h1: wb_transfer(1'b1, a, d, rdata); // Window write
			4'h2: begin
				wb_transfer(1'b0, a, '0, rdata);
				check_word($sformatf("read at %02h", a), rdata, exp);
			end
			4'h3: begin // Execute and then read back a GPR and the status
				wb_transfer(1'b1, `WB_ADDR_INSTR, d, rdata);
				wb_transfer(1'b0, a, '0, rdata);
				check_word($sformatf("read at %02h after %08h", a, d), rdata, exp);
				wb_transfer(1'b0, `WB_ADDR_STATUS, '0, rdata);
				check_status(exec_status_t'(rdata), exp_status);
			end
			default: stop_with_failure($sformatf("vector %0d has unknown kind %0h",
				vec_idx, kind));
		endcase
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count > timeout_limit) begin
			stop_with_failure($sformatf("timeout, run still busy after %0d cycles",
				cycle_count));
		end
	end

	initial begin
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_i = '0;
		sel = '0;
		for (int i = 0; i < 64; i++) begin
			vectors[i] = '0; // Kind 0 marks the end
		end
		$readmemh("dv/mips_exec_vectors.txt", vectors);
		num_vec = 0;
		num_xfers = 0;
		while (num_vec < 64 && vectors[num_vec][79:76] != 4'h0) begin
			num_xfers += (vectors[num_vec][79:76] == 4'h3) ? 3 : 1;
			num_vec++;
		end
		if (num_vec == 0) begin
			stop_with_failure("no vectors loaded from dv/mips_exec_vectors.txt");
		end
		// Reset sweep adds one read per GPR plus the status read
		timeout_limit = (num_xfers + `MIPS_NREGS + 1) * 8 + 50;

		@(negedge rst);
		check_reset_state();
		for (vec_idx = 0; vec_idx < num_vec; vec_idx++) begin
			run_vector(vectors[vec_idx]);
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk); // Held for 8 cycles
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// File: hw/mips_exec_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module mips_exec_top (
	input wire clk,
	input wire rst,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [`WB_ADDR_W-1:0] adr,
	input wire mips_exec_pkg::word_t dat_i,
	input wire [3:0] sel,
	output mips_exec_pkg::word_t dat_o,
	output logic ack
);
	import mips_isa_pkg::*;
	import mips_exec_pkg::*;

	instr_t instr;
	exec_ctrl_t ctrl;
	logic illegal;
	reg_idx_t rt;
	imm16_t imm;
	word_t imm_sext;
	word_t imm_zext;
	word_t rd_a;
	word_t rd_b;
	word_t op_b;
	word_t alu_result;
	logic alu_zero;
	logic movn_ok;
	reg_idx_t rf_ra;
	logic rf_we;
	reg_idx_t rf_wa;
	word_t rf_wd;

	assign rt = instr[20:16];
	assign imm = instr[15:0];
	assign imm_sext = {{(`MIPS_XLEN-16){imm[15]}}, imm}; // ADDI, ADDIU, SLTI
	assign imm_zext = {{(`MIPS_XLEN-16){1'b0}}, imm}; // Logic ops, LUI

	// Operand B select
	assign op_b = !ctrl.use_imm ? rd_b : (ctrl.imm_signed ? imm_sext : imm_zext);

	exec_wb_slave exec_wb_slave_i (
		.clk(clk),
		.rst(rst),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_i(dat_i),
		.sel(sel),
		.dat_o(dat_o),
		.ack(ack),
		.instr(instr),
		.ctrl(ctrl),
		.illegal(illegal),
		.alu_result(alu_result),
		.alu_zero(alu_zero),
		.movn_ok(movn_ok),
		.rf_ra(rf_ra),
		.rf_rd(rd_a), // Port A shared with window reads
		.rf_we(rf_we),
		.rf_wa(rf_wa),
		.rf_wd(rf_wd)
	);

	alu_decoder alu_decoder_i (
		.instr(instr),
		.ctrl(ctrl),
		.illegal(illegal)
	);

	reg_file reg_file_i (
		.clk(clk),
		.rst(rst),
		.ra_a(rf_ra),
		.ra_b(rt),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.we(rf_we),
		.wa(rf_wa),
		.wd(rf_wd)
	);

	alu alu_i (
		.a(rd_a),
		.b(op_b),
		.operation(ctrl.alu_op),
		.equal(ctrl.equal),
		.result(alu_result),
		.alu_zero(alu_zero),
		.movn_ok(movn_ok)
	);

endmodule

`default_nettype wire

// File: hw/exec_wb_slave.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module exec_wb_slave (
	input wire clk,
	input wire rst,
	input wire cyc,
	input wire stb,
	input wire we,
	input wire [`WB_ADDR_W-1:0] adr,
	input wire mips_exec_pkg::word_t dat_i,
	input wire [3:0] sel,
	output mips_exec_pkg::word_t dat_o,
	output logic ack,
	output mips_isa_pkg::instr_t instr, // To decoder and operand fetch
	input wire mips_exec_pkg::exec_ctrl_t ctrl,
	input wire illegal,
	input wire mips_exec_pkg::word_t alu_result,
	input wire alu_zero,
	input wire movn_ok,
	output mips_isa_pkg::reg_idx_t rf_ra,
	input wire mips_exec_pkg::word_t rf_rd,
	output logic rf_we,
	output mips_isa_pkg::reg_idx_t rf_wa,
	output mips_exec_pkg::word_t rf_wd
);
	import mips_isa_pkg::*;
	import mips_exec_pkg::*;

	wb_state_e state;
	logic [`WB_ADDR_W-1:0] adr_q; // Request latched in IDLE
	word_t dat_q;
	logic we_q;
	logic sel_full_q; // Byte writes are acked but ignored
	instr_t instr_q;
	exec_status_t status_q;

	logic exec_hit; // Full-word write to the instruction address
	logic win_hit; // Access inside the GPR window
	reg_idx_t win_idx;

	assign exec_hit = we_q && sel_full_q && (adr_q == `WB_ADDR_INSTR);
	assign win_hit = (adr_q >= `WB_REG_BASE) && (adr_q[1:0] == 2'b00);
	assign win_idx = adr_q[2 +: $bits(reg_idx_t)]; // One GPR per word

	assign instr = instr_q;
	assign ack = (state == ACK); // Single-cycle, never stretched

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			status_q <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (cyc && stb) begin
						state <= ACK;
					end
				end
				ACK: begin
					state <= IDLE; // Master drops stb next cycle
					if (exec_hit) begin // Status only follows instructions
						status_q.branch_taken <= ctrl.is_branch && alu_zero;
						status_q.movn_blocked <= (ctrl.alu_op == ALU_MOVN) && !movn_ok;
						status_q.illegal <= illegal;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Request capture
	always_ff @(posedge clk) begin
		if (state == IDLE && cyc && stb) begin
			adr_q <= adr;
			dat_q <= dat_i;
			we_q <= we;
			sel_full_q <= (sel == 4'hF);
			if (we && (sel == 4'hF) && (adr == `WB_ADDR_INSTR)) begin
				instr_q <= dat_i; // Decoded during ACK
			end
		end
	end

	// Port A serves rs, or the window index on window reads
	assign rf_ra = win_hit ? win_idx : instr_q[25:21];

	// Single write port, written at the edge that leaves ACK
	always_comb begin
		rf_we = 1'b0;
		rf_wa = ctrl.dest;
		rf_wd = alu_result;
		if (state == ACK) begin
			if (exec_hit) begin
				rf_we = ctrl.reg_write && movn_ok; // MOVN with rt zero blocked
			end else if (win_hit && we_q && sel_full_q) begin
				rf_we = 1'b1;
				rf_wa = win_idx;
				rf_wd = dat_q;
			end
		end
	end

	// Read data valid only while ack is high
	always_comb begin
		dat_o = '0; // Unmapped reads return zero
		if (state == ACK && !we_q) begin
			if (adr_q == `WB_ADDR_STATUS) begin
				dat_o = word_t'(status_q);
			end else if (win_hit) begin
				dat_o = rf_rd;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_macros.svh"

module reg_file (
	input wire clk,
	input wire rst,
	input wire mips_isa_pkg::reg_idx_t ra_a, // rs or window index
	input wire mips_isa_pkg::reg_idx_t ra_b, // rt
	output mips_exec_pkg::word_t rd_a,
	output mips_exec_pkg::word_t rd_b,
	input wire we,
	input wire mips_isa_pkg::reg_idx_t wa,
	input wire mips_exec_pkg::word_t wd
);
	import mips_exec_pkg::*;

	word_t regs [`MIPS_NREGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MIPS_NREGS; i++) begin
				regs[i] <= '0; // All GPRs read zero after reset
			end
		end else if (we && (wa != '0)) begin // r0 writes dropped
			regs[wa] <= wd;
		end
	end

	// Async reads, r0 stays zero since it is never written
	assign rd_a = regs[ra_a];
	assign rd_b = regs[ra_b];

endmodule

`default_nettype wire

// File: hw/alu_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module alu_decoder (
	input wire mips_isa_pkg::instr_t instr,
	output mips_exec_pkg::exec_ctrl_t ctrl,
	output logic illegal // Opcode/funct not supported
);
	import mips_isa_pkg::*;
	import mips_exec_pkg::*;

	opcode_e opcode;
	funct_e funct;
	reg_idx_t rt;
	reg_idx_t rd;

	assign opcode = opcode_e'(instr[31:26]);
	assign funct = funct_e'(instr[5:0]);
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = ALU_ILLEGAL;
		ctrl.dest = rt; // I-type default
		ctrl.reg_write = 1'b1;
		illegal = 1'b0;

		case (opcode)
			OP_SPECIAL: begin
				ctrl.dest = rd; // R-type writes rd
				case (funct)
					FN_AND: ctrl.alu_op = ALU_AND;
					FN_OR: ctrl.alu_op = ALU_OR;
					FN_ADD: ctrl.alu_op = ALU_ADD;
					FN_ADDU: ctrl.alu_op = ALU_ADDU;
					FN_MOVN: ctrl.alu_op = ALU_MOVN; // ALU gates the write
					FN_SUB: ctrl.alu_op = ALU_SUB;
					FN_SUBU: ctrl.alu_op = ALU_SUBU;
					FN_SLT: ctrl.alu_op = ALU_SLT;
					FN_NOR: ctrl.alu_op = ALU_NOR;
					FN_XOR: ctrl.alu_op = ALU_XOR;
					default: illegal = 1'b1;
				endcase
			end

			OP_REGIMM: begin
				if (rt == reg_idx_t'(1)) begin // BGEZ only, no BGEZAL
					ctrl.alu_op = ALU_BGEZ;
					ctrl.is_branch = 1'b1;
					ctrl.reg_write = 1'b0;
				end else begin
					illegal = 1'b1;
				end
			end

			OP_BEQ, OP_BNE: begin
				ctrl.alu_op = ALU_SUB; // Compare through subtract
				ctrl.is_branch = 1'b1;
				ctrl.equal = (opcode == OP_BEQ);
				ctrl.reg_write = 1'b0;
			end

			OP_ADDI, OP_ADDIU, OP_SLTI: begin
				ctrl.use_imm = 1'b1;
				ctrl.imm_signed = 1'b1; // All three sign-extend
				ctrl.alu_op = (opcode == OP_ADDI) ? ALU_ADD :
					(opcode == OP_ADDIU) ? ALU_ADDU : ALU_SLT;
			end

			OP_ANDI: begin
				ctrl.use_imm = 1'b1; // Zero-extended
				ctrl.alu_op = ALU_AND;
			end

			OP_ORI: begin
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = ALU_OR;
			end

			OP_XORI: begin
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = ALU_XOR;
			end

			OP_LUI: begin
				ctrl.use_imm = 1'b1; // ALU shifts it up
				ctrl.alu_op = ALU_LUI;
			end

			default: illegal = 1'b1;
		endcase

		// Unsupported encodings never touch the GPRs
		if (illegal) begin
			ctrl.alu_op = ALU_ILLEGAL;
			ctrl.reg_write = 1'b0;
			ctrl.is_branch = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
	input wire mips_exec_pkg::word_t a, // rs value
	input wire mips_exec_pkg::word_t b, // rt value or immediate
	input wire mips_exec_pkg::alu_op_e operation,
	input wire equal, // Branch sense for BEQ vs BNE
	output mips_exec_pkg::word_t result,
	output logic alu_zero, // Branch condition met
	output logic movn_ok // Low blocks the MOVN write-back
);
	import mips_exec_pkg::*;

	always_comb begin
		result = '0; // Flag-only ops return zero
		alu_zero = 1'b0;
		movn_ok = 1'b1;

		case (operation)
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_ADD: result = $signed(a) + $signed(b); // Wraps with no overflow trap
			ALU_ADDU: result = a + b;

			ALU_MOVN: begin
				if (b != '0) begin // Non-zero rt moves rs to rd
					result = a;
				end else begin
					movn_ok = 1'b0; // Zero rt leaves rd unchanged
				end
			end

			ALU_SUB: begin // SUB and BEQ/BNE share this code
				result = $signed(a) - $signed(b);
				if (equal) begin
					alu_zero = (a == b); // BEQ
				end else begin
					alu_zero = (a != b); // BNE
				end
			end

			ALU_SUBU: result = a - b;

			ALU_BGEZ: begin
				alu_zero = ($signed(a) >= 0); // Taken when rs non-negative
				result[0] = alu_zero;
			end

			ALU_SLT: result[0] = ($signed(a) < $signed(b)); // Signed compare

			ALU_NOR: result = ~(a | b);
			ALU_XOR: result = a ^ b;
			ALU_LUI: result = b << 16; // Immediate to upper half

			// Unknown and ALU_ILLEGAL land here
			default: result = 32'hdeadbeef;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/mips_exec_pkg.sv
`default_nettype none

`include "mips_macros.svh"

package mips_exec_pkg;

	typedef logic [`MIPS_XLEN-1:0] word_t; // GPR / ALU data word

	// ALU operation codes
	typedef enum logic [3:0] {
		ALU_AND = 4'b0000,
		ALU_OR = 4'b0001,
		ALU_ADD = 4'b0010,
		ALU_ADDU = 4'b0011,
		ALU_MOVN = 4'b0100,
		ALU_SUB = 4'b0110, // Also BEQ/BNE compare
		ALU_SUBU = 4'b0111,
		ALU_BGEZ = 4'b1000,
		ALU_SLT = 4'b1001,
		ALU_NOR = 4'b1100,
		ALU_XOR = 4'b1101,
		ALU_ILLEGAL = 4'b1110, // ALU returns deadbeef for it
		ALU_LUI = 4'b1111
	} alu_op_e;

	// Decoder output
	typedef struct packed {
		alu_op_e alu_op;
		logic use_imm; // Operand B from immediate
		logic imm_signed; // Sign-extend vs zero-extend
		mips_isa_pkg::reg_idx_t dest; // rd or rt
		logic reg_write; // GPR write-back wanted
		logic is_branch;
		logic equal; // High for BEQ and low for BNE
	} exec_ctrl_t;

	// Status word with branch_taken in bit 0
	typedef struct packed {
		logic [28:0] reserved;
		logic illegal;
		logic movn_blocked;
		logic branch_taken;
	} exec_status_t;

	typedef enum logic {
		IDLE,
		ACK
	} wb_state_e;

endpackage

`default_nettype wire

// File: hw/mips_isa_pkg.sv
`default_nettype none

`include "mips_macros.svh"

package mips_isa_pkg;

	typedef logic [$clog2(`MIPS_NREGS)-1:0] reg_idx_t; // GPR index, rs/rt/rd
	typedef logic [15:0] imm16_t; // I-type immediate field
	typedef logic [31:0] instr_t; // Raw instruction word

	// Primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, // R-type, decoded by funct
		OP_REGIMM = 6'h01, // Decoded by rt, only BGEZ here
		OP_BEQ = 6'h04,
		OP_BNE = 6'h05,
		OP_ADDI = 6'h08,
		OP_ADDIU = 6'h09,
		OP_SLTI = 6'h0a,
		OP_ANDI = 6'h0c,
		OP_ORI = 6'h0d,
		OP_XORI = 6'h0e,
		OP_LUI = 6'h0f
	} opcode_e;

	// SPECIAL funct field, instr[5:0]
	typedef enum logic [5:0] {
		FN_MOVN = 6'h0b,
		FN_ADD = 6'h20,
		FN_ADDU = 6'h21,
		FN_SUB = 6'h22,
		FN_SUBU = 6'h23,
		FN_AND = 6'h24,
		FN_OR = 6'h25,
		FN_XOR = 6'h26,
		FN_NOR = 6'h27,
		FN_SLT = 6'h2a
	} funct_e;

endpackage

`default_nettype wire

// File: include/mips_macros.svh
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Datapath sizing, fixed by the ISA
`define MIPS_XLEN 32 // Data word width
`define MIPS_NREGS 32 // GPR count, r0 hardwired to zero

// Wishbone slave address map, byte addresses on an 8-bit bus
`define WB_ADDR_W 8 // Slave address width

// Writing an instruction word here executes it
`define WB_ADDR_INSTR 8'h00

// Read-only, branch/movn/illegal flags of the last instruction
`define WB_ADDR_STATUS 8'h04

// GPR window, r0 at 8'h80 up to r31 at 8'hFC
`define WB_REG_BASE 8'h80

`endif
